/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_axis_matmul
FILELIST  = sim.f
OBJDIR    = obj_dir
RUNARGS   = +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP) $(RUNARGS))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf $(OBJDIR)

/* logic/axis_matmul_top.sv */
/* Streaming 4x4 Q8.8 matrix-multiply accelerator
   Input and weight AXI-Stream rows in, result rows out with tlast */
`timescale 1ns/1ps

module axis_matmul_top (
    input  logic                           aclk,
    input  logic                           aresetn,
    output logic                           s_axis_i_tready_o,
    input  logic [mm_pkg::ROW_WIDTH-1:0]   s_axis_i_tdata_i,
    input  logic                           s_axis_i_tvalid_i,
    input  logic                           s_axis_i_tlast_i,
    output logic                           s_axis_w_tready_o,
    input  logic [mm_pkg::ROW_WIDTH-1:0]   s_axis_w_tdata_i,
    input  logic                           s_axis_w_tvalid_i,
    input  logic                           s_axis_w_tlast_i,
    input  logic                           m_axis_tready_i,
    output logic [mm_pkg::ROW_WIDTH-1:0]   m_axis_tdata_o,
    output logic                           m_axis_tvalid_o,
    output logic                           m_axis_tlast_o
);
    import mm_pkg::*;

    logic [ROW_WIDTH-1:0]        a_head;           // Input FIFO head
    logic [ROW_WIDTH-1:0]        w_head;           // Weight FIFO head
    logic [COUNT_WIDTH-1:0]      i_count;
    logic [COUNT_WIDTH-1:0]      w_count;
    logic [COUNT_WIDTH-1:0]      out_count;
    logic                        pop;
    logic                        st_wr_en;
    logic [ROW_IDX_WIDTH-1:0]    st_wr_idx;
    logic [ROW_IDX_WIDTH-1:0]    st_rd_idx;
    logic [ROW_WIDTH-1:0]        st_a_row;
    logic [W_ROWS*ROW_WIDTH-1:0] st_w_rows;
    logic                        issue;
    logic                        res_valid;
    logic [ROW_WIDTH-1:0]        res_row;
    logic                        res_last;
    logic                        mac_busy;

    // Input rows, tlast stored but ignored
    stream_fifo #(.DATA_WIDTH(ROW_WIDTH), .DEPTH(FIFO_DEPTH)) in_fifo (
        .aclk(aclk), .aresetn(aresetn),
        .wr_valid_i(s_axis_i_tvalid_i), .wr_data_i(s_axis_i_tdata_i),
        .wr_last_i(s_axis_i_tlast_i), .wr_ready_o(s_axis_i_tready_o),
        .rd_valid_o(), .rd_data_o(a_head), .rd_last_o(),
        .rd_ready_i(pop), .count_o(i_count)
    );

    // Weight rows
    stream_fifo #(.DATA_WIDTH(ROW_WIDTH), .DEPTH(FIFO_DEPTH)) wt_fifo (
        .aclk(aclk), .aresetn(aresetn),
        .wr_valid_i(s_axis_w_tvalid_i), .wr_data_i(s_axis_w_tdata_i),
        .wr_last_i(s_axis_w_tlast_i), .wr_ready_o(s_axis_w_tready_o),
        .rd_valid_o(), .rd_data_o(w_head), .rd_last_o(),
        .rd_ready_i(pop), .count_o(w_count)
    );

    operand_store u_store (
        .aclk(aclk), .aresetn(aresetn),
        .wr_en_i(st_wr_en), .wr_idx_i(st_wr_idx),
        .a_row_i(a_head), .w_row_i(w_head),
        .rd_idx_i(st_rd_idx), .a_row_o(st_a_row), .w_rows_o(st_w_rows)
    );

    row_mac u_mac (
        .aclk(aclk), .aresetn(aresetn), .issue_i(issue),
        .a_row_i(st_a_row), .w_rows_i(st_w_rows),
        .res_valid_o(res_valid), .res_row_o(res_row), .busy_o(mac_busy)
    );

    mm_controller u_ctrl (
        .aclk(aclk), .aresetn(aresetn),
        .i_count_i(i_count), .w_count_i(w_count), .pop_o(pop),
        .wr_en_o(st_wr_en), .wr_idx_o(st_wr_idx), .rd_idx_o(st_rd_idx),
        .issue_o(issue), .res_last_o(res_last),
        .out_count_i(out_count), .mac_busy_i(mac_busy)
    );

    // Result rows, never full on write thanks to credits
    stream_fifo #(.DATA_WIDTH(ROW_WIDTH), .DEPTH(FIFO_DEPTH)) out_fifo (
        .aclk(aclk), .aresetn(aresetn),
        .wr_valid_i(res_valid), .wr_data_i(res_row),
        .wr_last_i(res_last), .wr_ready_o(),
        .rd_valid_o(m_axis_tvalid_o), .rd_data_o(m_axis_tdata_o),
        .rd_last_o(m_axis_tlast_o), .rd_ready_i(m_axis_tready_i),
        .count_o(out_count)
    );

endmodule

/* logic/mm_controller.sv */
/* Job controller for the matrix-multiply accelerator
   Waits for a full job, loads the store, issues rows against output credits */
`timescale 1ns/1ps

module mm_controller (
    input  logic                              aclk,
    input  logic                              aresetn,
    input  logic [mm_pkg::COUNT_WIDTH-1:0]    i_count_i,
    input  logic [mm_pkg::COUNT_WIDTH-1:0]    w_count_i,
    output logic                              pop_o,
    output logic                              wr_en_o,
    output logic [mm_pkg::ROW_IDX_WIDTH-1:0]  wr_idx_o,
    output logic [mm_pkg::ROW_IDX_WIDTH-1:0]  rd_idx_o,
    output logic                              issue_o,
    output logic                              res_last_o,
    input  logic [mm_pkg::COUNT_WIDTH-1:0]    out_count_i,
    input  logic                              mac_busy_i
);
    import mm_pkg::*;

    ctrl_state_t              state_q;
    ctrl_state_t              state_d;
    logic [ROW_IDX_WIDTH-1:0] load_cnt_q;            // Rows copied so far
    logic [ROW_IDX_WIDTH-1:0] issue_cnt_q;           // Result rows issued so far
    logic                     iss_v1_q;              // Issue in MAC stage 1
    logic                     iss_v2_q;              // Issue in MAC stage 2
    logic [ROW_IDX_WIDTH-1:0] iss_idx1_q;
    logic [ROW_IDX_WIDTH-1:0] iss_idx2_q;
    logic [COUNT_WIDTH-1:0]   free_slots;
    logic [COUNT_WIDTH-1:0]   in_flight;
    logic                     credit_ok;
    logic                     job_ready;
    logic                     load_last;
    logic                     issue_last;

    // Both FIFOs hold a whole job
    assign job_ready  = (i_count_i >= COUNT_WIDTH'(A_ROWS))
                     && (w_count_i >= COUNT_WIDTH'(W_ROWS));

    // Credits, free output slots minus rows still in the MAC
    assign free_slots = COUNT_WIDTH'(FIFO_DEPTH) - out_count_i;
    assign in_flight  = COUNT_WIDTH'(iss_v1_q) + COUNT_WIDTH'(iss_v2_q);
    assign credit_ok  = (free_slots > in_flight);

    assign load_last  = (load_cnt_q == ROW_IDX_WIDTH'(A_ROWS-1));
    assign issue_last = (issue_cnt_q == ROW_IDX_WIDTH'(A_ROWS-1));

    // Store and FIFO side
    assign pop_o    = (state_q == S_LOAD);           // One A and one W row per cycle
    assign wr_en_o  = (state_q == S_LOAD);
    assign wr_idx_o = load_cnt_q;
    assign rd_idx_o = issue_cnt_q;
    assign issue_o  = (state_q == S_COMPUTE) && credit_ok;

    // Row 3 entering the output FIFO
    assign res_last_o = iss_v2_q && (iss_idx2_q == ROW_IDX_WIDTH'(A_ROWS-1));

    // Next state
    always_comb
    begin
        state_d = state_q;
        case (state_q)
            S_WAIT:
            begin
                if (job_ready)
                    state_d = S_LOAD;
            end
            S_LOAD:
            begin
                if (load_last)
                    state_d = S_COMPUTE;             // Exactly A_ROWS load cycles
            end
            S_COMPUTE:
            begin
                if (issue_o && issue_last)
                    state_d = S_DRAIN;
            end
            S_DRAIN:
            begin
                if (!mac_busy_i)
                    state_d = S_WAIT;                // Pipeline empty, next job
            end
            default: state_d = S_WAIT;
        endcase
    end

    // State, counters and the issue shadow pipeline
    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            state_q     <= S_WAIT;
            load_cnt_q  <= '0;
            issue_cnt_q <= '0;
            iss_v1_q    <= 1'b0;
            iss_v2_q    <= 1'b0;
            iss_idx1_q  <= '0;
            iss_idx2_q  <= '0;
        end
        else
        begin
            state_q <= state_d;
            if (state_q == S_LOAD)
                load_cnt_q <= load_last ? '0 : load_cnt_q + 1'b1;
            if (issue_o)
                issue_cnt_q <= issue_last ? '0 : issue_cnt_q + 1'b1;
            iss_v1_q   <= issue_o;                   // Mirrors row_mac timing
            iss_v2_q   <= iss_v1_q;
            iss_idx1_q <= issue_cnt_q;
            iss_idx2_q <= iss_idx1_q;
        end
    end

endmodule

/* logic/mm_pkg.sv */
/* Matrix-multiply accelerator package
   Sizes, Q8.8 fixed-point constants and the controller state encoding */
package mm_pkg;

    // Element format
    localparam int ELEM_WIDTH = 16;                      // Signed Q8.8 element
    localparam int FRAC_WIDTH = 8;                       // Fractional bits

    // Matrix geometry
    localparam int ROW_ELEMS  = 4;                       // Inner dimension
    localparam int ROW_WIDTH  = ROW_ELEMS * ELEM_WIDTH;  // One stream beat
    localparam int A_ROWS     = 4;                       // Input rows, also result rows
    localparam int W_ROWS     = 4;                       // Weight rows, also result columns

    // Buffering
    localparam int FIFO_DEPTH    = 8;                    // Room for a job plus the next one
    localparam int COUNT_WIDTH   = 4;                    // Holds 0..FIFO_DEPTH
    localparam int ROW_IDX_WIDTH = 2;                    // Row index 0..3

    // Controller states
    typedef enum logic [1:0] {
        S_WAIT    = 2'd0,                                // Wait for a full job in both FIFOs
        S_LOAD    = 2'd1,                                // Copy rows into the operand store
        S_COMPUTE = 2'd2,                                // Issue result rows against credits
        S_DRAIN   = 2'd3                                 // Let the MAC pipeline empty
    } ctrl_state_t;

endpackage

/* logic/operand_store.sv */
/* Operand store for one job
   Holds four A rows and four W rows; reads one A row and all W rows */
`timescale 1ns/1ps

module operand_store (
    input  logic                                     aclk,
    input  logic                                     aresetn,
    input  logic                                     wr_en_i,
    input  logic [mm_pkg::ROW_IDX_WIDTH-1:0]         wr_idx_i,
    input  logic [mm_pkg::ROW_WIDTH-1:0]             a_row_i,
    input  logic [mm_pkg::ROW_WIDTH-1:0]             w_row_i,
    input  logic [mm_pkg::ROW_IDX_WIDTH-1:0]         rd_idx_i,
    output logic [mm_pkg::ROW_WIDTH-1:0]             a_row_o,
    output logic [mm_pkg::W_ROWS*mm_pkg::ROW_WIDTH-1:0] w_rows_o
);
    import mm_pkg::*;

    logic [ROW_WIDTH-1:0] a_rows_q [A_ROWS];        // Input matrix rows
    logic [ROW_WIDTH-1:0] w_rows_q [W_ROWS];        // Weight matrix rows
    logic                 wr_ok;

    // Writes held off while in reset
    assign wr_ok = aresetn && wr_en_i;

    // A and W rows land together at one index
    always_ff @(posedge aclk)
    begin
        if (wr_ok)
        begin
            a_rows_q[wr_idx_i] <= a_row_i;
            w_rows_q[wr_idx_i] <= w_row_i;
        end
    end

    // Selected A row
    assign a_row_o = a_rows_q[rd_idx_i];

    // All W rows flattened, row j at bits j*ROW_WIDTH up
    always_comb
    begin
        for (int j = 0; j < W_ROWS; j++)
        begin
            w_rows_o[j*ROW_WIDTH +: ROW_WIDTH] = w_rows_q[j];
        end
    end

endmodule

/* logic/row_mac.sv */
/* Two-stage row multiply-accumulate
   One A row times all W rows gives one packed Q8.8 result row */
`timescale 1ns/1ps

module row_mac (
    input  logic                                        aclk,
    input  logic                                        aresetn,
    input  logic                                        issue_i,
    input  logic [mm_pkg::ROW_WIDTH-1:0]                a_row_i,
    input  logic [mm_pkg::W_ROWS*mm_pkg::ROW_WIDTH-1:0] w_rows_i,
    output logic                                        res_valid_o,
    output logic [mm_pkg::ROW_WIDTH-1:0]                res_row_o,
    output logic                                        busy_o
);
    import mm_pkg::*;

    logic signed [2*ELEM_WIDTH-1:0] prod_full [W_ROWS][ROW_ELEMS]; // Full-precision products
    logic        [ELEM_WIDTH-1:0]   prod_q    [W_ROWS][ROW_ELEMS]; // Scaled, truncated
    logic        [ELEM_WIDTH-1:0]   sum_d     [W_ROWS];
    logic                           s1_valid_q;

    // Stage 1 products, A[k] * W[j][k]
    always_comb
    begin
        for (int j = 0; j < W_ROWS; j++)
        begin
            for (int k = 0; k < ROW_ELEMS; k++)
            begin
                prod_full[j][k] = $signed(a_row_i[k*ELEM_WIDTH +: ELEM_WIDTH])
                                * $signed(w_rows_i[j*ROW_WIDTH + k*ELEM_WIDTH +: ELEM_WIDTH]);
            end
        end
    end

    always_ff @(posedge aclk)
    begin
        for (int j = 0; j < W_ROWS; j++)
            for (int k = 0; k < ROW_ELEMS; k++)
                prod_q[j][k] <= ELEM_WIDTH'(prod_full[j][k] >>> FRAC_WIDTH); // Back to Q8.8
    end

    // Stage 2 sums, 16-bit wraparound
    always_comb
    begin
        for (int j = 0; j < W_ROWS; j++)
        begin
            sum_d[j] = '0;
            for (int k = 0; k < ROW_ELEMS; k++)
                sum_d[j] = sum_d[j] + prod_q[j][k];
        end
    end

    always_ff @(posedge aclk)
    begin
        for (int j = 0; j < W_ROWS; j++)
            res_row_o[j*ELEM_WIDTH +: ELEM_WIDTH] <= sum_d[j]; // Element j of row
    end

    // Valid pipeline
    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            s1_valid_q  <= 1'b0;
            res_valid_o <= 1'b0;
        end
        else
        begin
            s1_valid_q  <= issue_i;
            res_valid_o <= s1_valid_q;                 // Two cycles issue to write
        end
    end

    assign busy_o = s1_valid_q || res_valid_o;

endmodule

/* logic/stream_fifo.sv */
/* Synchronous valid/ready FIFO
   Circular buffer of data plus last bit, with occupancy count */
`timescale 1ns/1ps

module stream_fifo #(
    parameter int DATA_WIDTH = mm_pkg::ROW_WIDTH,
    parameter int DEPTH      = mm_pkg::FIFO_DEPTH
) (
    input  logic                         aclk,
    input  logic                         aresetn,
    input  logic                         wr_valid_i,
    input  logic [DATA_WIDTH-1:0]        wr_data_i,
    input  logic                         wr_last_i,
    output logic                         wr_ready_o,
    output logic                         rd_valid_o,
    output logic [DATA_WIDTH-1:0]        rd_data_o,
    output logic                         rd_last_o,
    input  logic                         rd_ready_i,
    output logic [$clog2(DEPTH+1)-1:0]   count_o
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [DATA_WIDTH:0]          mem [DEPTH];      // Last bit on top of data
    logic [PTR_W-1:0]             wr_ptr_q;
    logic [PTR_W-1:0]             rd_ptr_q;
    logic [$clog2(DEPTH+1)-1:0]   count_q;
    logic                         wr_fire;
    logic                         rd_fire;

    assign wr_ready_o = (count_q != DEPTH);         // Back-pressure only when full
    assign rd_valid_o = (count_q != 0);
    assign wr_fire    = wr_valid_i && wr_ready_o;
    assign rd_fire    = rd_valid_o && rd_ready_i;

    assign rd_data_o  = mem[rd_ptr_q][DATA_WIDTH-1:0]; // Head is combinational
    assign rd_last_o  = mem[rd_ptr_q][DATA_WIDTH];
    assign count_o    = count_q;

    // Storage array, no reset
    always_ff @(posedge aclk)
    begin
        if (wr_fire)
            mem[wr_ptr_q] <= {wr_last_i, wr_data_i};
    end

    // Pointers and occupancy
    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (wr_fire)
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH-1)) ? '0 : wr_ptr_q + 1'b1; // Wrap at depth
            if (rd_fire)
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH-1)) ? '0 : rd_ptr_q + 1'b1;
            if (wr_fire && !rd_fire)
                count_q <= count_q + 1'b1;
            else if (rd_fire && !wr_fire)
                count_q <= count_q - 1'b1;               // Simultaneous push/pop keeps count
        end
    end

endmodule

/* sim.f */
logic/mm_pkg.sv
logic/stream_fifo.sv
logic/operand_store.sv
logic/row_mac.sv
logic/mm_controller.sv
logic/axis_matmul_top.sv
tests/tb_axis_matmul_asserts.sv
tests/tb_axis_matmul.sv

/* tests/tb_axis_matmul.sv */
/* Testbench for the streaming matrix-multiply accelerator
   Queues operand jobs, models result rows and checks every output beat */
`timescale 1ns/1ps

module tb_axis_matmul;
    import mm_pkg::*;

    localparam int NUM_JOBS   = 8;                          // Jobs over all tests
    localparam int W_DELAY    = 40;                         // Weight lag in the gating test
    localparam int MAX_CYCLES = NUM_JOBS * 120 + W_DELAY;   // 120 cycles per stalled job

    logic                 aclk = 1'b0;                      // Low from the start, no edge at 0
    logic                 aresetn;
    logic                 i_tready;
    logic                 i_tvalid;
    logic [ROW_WIDTH-1:0] i_tdata;
    logic                 w_tready;
    logic                 w_tvalid;
    logic [ROW_WIDTH-1:0] w_tdata;
    logic                 m_tready;
    logic                 m_tvalid;
    logic                 m_tlast;
    logic [ROW_WIDTH-1:0] m_tdata;
    logic [ROW_WIDTH-1:0] a_q [$];                          // Rows waiting for the ports
    logic [ROW_WIDTH-1:0] w_q [$];
    logic [ROW_WIDTH-1:0] job_a [A_ROWS];
    logic [ROW_WIDTH-1:0] job_w [W_ROWS];
    logic [ROW_WIDTH-1:0] exp_rows [NUM_JOBS*A_ROWS];       // Model output in order
    logic [ROW_WIDTH-1:0] exp_cur;
    logic                 i_go = 1'b0;                      // Beat on the bus leaves at next rise
    logic                 w_go = 1'b0;
    logic                 w_gate = 1'b1;                    // Holds weight rows back
    logic                 rand_ready = 1'b0;
    int                   seed = 65472;
    int                   exp_wr = 0;
    int                   out_beats = 0;
    int                   i_acc = 0;
    int                   w_acc = 0;
    int                   cycles = 0;
    int                   err_cnt = 0;
    int                   errs_mark = 0;
    int                   tests_run = 0;

    axis_matmul_top DUT (
        .aclk(aclk), .aresetn(aresetn),
        .s_axis_i_tready_o(i_tready), .s_axis_i_tdata_i(i_tdata),
        .s_axis_i_tvalid_i(i_tvalid), .s_axis_i_tlast_i(1'b0),
        .s_axis_w_tready_o(w_tready), .s_axis_w_tdata_i(w_tdata),
        .s_axis_w_tvalid_i(w_tvalid), .s_axis_w_tlast_i(1'b0),
        .m_axis_tready_i(m_tready), .m_axis_tdata_o(m_tdata),
        .m_axis_tvalid_o(m_tvalid), .m_axis_tlast_o(m_tlast)
    );

    bind axis_matmul_top tb_axis_matmul_asserts chk (
        .aclk(aclk), .aresetn(aresetn), .s_i_tready_i(s_axis_i_tready_o),
        .s_w_tready_i(s_axis_w_tready_o), .m_tvalid_i(m_axis_tvalid_o),
        .m_tready_i(m_axis_tready_i), .m_tdata_i(m_axis_tdata_o), .m_tlast_i(m_axis_tlast_o)
    );

    initial
    begin
        forever #4 aclk = ~aclk;                            // 8 ns period
    end

    // Port drivers, a beat holds until taken
    always @(negedge aclk)
    begin
        if (!i_tvalid || i_go)
        begin
            i_tvalid = (a_q.size() != 0);
            if (i_tvalid)
                i_tdata = a_q.pop_front();
        end
        if (!w_tvalid || w_go)
        begin
            w_tvalid = w_gate && (w_q.size() != 0);
            if (w_tvalid)
                w_tdata = w_q.pop_front();
        end
        i_go = i_tvalid && i_tready;                        // Ready stable until the rise
        w_go = w_tvalid && w_tready;
        m_tready = rand_ready ? 1'($random(seed)) : 1'b1;
    end

    // Transfer counts and run limit
    always @(posedge aclk)
    begin
        if (aresetn)
        begin
            i_acc     <= i_acc + int'(i_tvalid && i_tready);
            w_acc     <= w_acc + int'(w_tvalid && w_tready);
            out_beats <= out_beats + int'(m_tvalid && m_tready);
        end
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    assign exp_cur = exp_rows[out_beats];                   // Row due on the next transfer

    task automatic note_fail(input string msg);
        $display("FAIL %0t: %s", $time, msg);
        err_cnt++;
    endtask

    a_reset: assert property (@(posedge aclk)
        $rose(aresetn) |-> !m_tvalid && i_tready && w_tready)
        else note_fail("port handshakes not idle after reset");
    a_data: assert property (@(posedge aclk) disable iff (!aresetn)
        m_tvalid && m_tready |-> m_tdata == exp_cur)
        else note_fail("result row differs from the model");
    a_last: assert property (@(posedge aclk) disable iff (!aresetn)
        m_tvalid && m_tready |-> m_tlast == (out_beats % A_ROWS == A_ROWS - 1))
        else note_fail("tlast not on the fourth beat of a job");
    // Never ahead of fully accepted jobs, never beyond the model
    a_gate: assert property (@(posedge aclk) disable iff (!aresetn)
        m_tvalid |-> out_beats < exp_wr
            && out_beats < A_ROWS * (((i_acc < w_acc) ? i_acc : w_acc) / A_ROWS))
        else note_fail("output beat with no fully accepted job behind it");

    task automatic random_job();
        for (int r = 0; r < A_ROWS; r++)
        begin
            job_a[r] = {$random(seed), $random(seed)};
            job_w[r] = {$random(seed), $random(seed)};
        end
    endtask

    // Q8.8 reference rows, then operands go to the drivers
    task automatic queue_job();
        logic signed [2*ELEM_WIDTH-1:0] prod;
        logic        [ELEM_WIDTH-1:0]   acc;
        for (int i = 0; i < A_ROWS; i++)
        begin
            for (int j = 0; j < W_ROWS; j++)
            begin
                acc = '0;
                for (int k = 0; k < ROW_ELEMS; k++)
                begin
                    prod = $signed(job_a[i][16*k +: 16]) * $signed(job_w[j][16*k +: 16]);
                    prod = prod >>> FRAC_WIDTH;             // Full product scaled back
                    acc  = acc + prod[ELEM_WIDTH-1:0];      // Wraps at 16 bits
                end
                exp_rows[exp_wr][16*j +: 16] = acc;
            end
            exp_wr++;
        end
        for (int r = 0; r < A_ROWS; r++)
        begin
            a_q.push_back(job_a[r]);
            w_q.push_back(job_w[r]);
        end
    endtask

    task automatic wait_outputs();
        while (out_beats != exp_wr)
            @(negedge aclk);
        repeat (4) @(negedge aclk);                         // Room for a stray extra beat
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = err_cnt + DUT.chk.fail_cnt;
        tests_run++;
        $display("Test %0d %s: %0d errors", tests_run, name, errs - errs_mark);
        errs_mark = errs;
    endtask

    initial
    begin
        aresetn  = 1'b0;
        i_tvalid = 1'b0;
        i_tdata  = '0;
        w_tvalid = 1'b0;
        w_tdata  = '0;
        m_tready = 1'b1;
        repeat (2) @(negedge aclk);                         // Two rising edges in reset
        aresetn = 1'b1;
        repeat (2) @(negedge aclk);
        end_test("reset state");
        random_job();
        for (int r = 0; r < W_ROWS; r++)
            job_w[r] = ROW_WIDTH'(16'h0100) << (ELEM_WIDTH * r); // Q8.8 identity
        queue_job();
        random_job();
        queue_job();
        wait_outputs();
        end_test("identity and random weights");
        for (int r = 0; r < A_ROWS; r++)
        begin
            job_a[r] = {4{16'h7fff}};
            job_w[r] = {4{16'h8001}};                       // Large products force wraparound
        end
        queue_job();
        random_job();
        queue_job();
        wait_outputs();
        end_test("tlast framing and wraparound");
        w_gate = 1'b0;
        random_job();
        queue_job();
        repeat (W_DELAY) @(negedge aclk);
        w_gate = 1'b1;
        wait_outputs();
        end_test("late weight rows");
        repeat (3)
        begin
            random_job();
            queue_job();
        end
        rand_ready = 1'b1;                                  // Three jobs under back-pressure
        wait_outputs();
        end_test("random output back-pressure");
        $display("Tests run: %0d, errors: %0d", tests_run, err_cnt + DUT.chk.fail_cnt);
        if (err_cnt + DUT.chk.fail_cnt == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

/* tests/tb_axis_matmul_asserts.sv */
/* Bound AXI-Stream checks on the accelerator ports
   Output hold and stability rules, no unknown values after reset */
`timescale 1ns/1ps

module tb_axis_matmul_asserts (
    input  logic                         aclk,
    input  logic                         aresetn,
    input  logic                         s_i_tready_i,
    input  logic                         s_w_tready_i,
    input  logic                         m_tvalid_i,
    input  logic                         m_tready_i,
    input  logic [mm_pkg::ROW_WIDTH-1:0] m_tdata_i,
    input  logic                         m_tlast_i
);
    int fail_cnt = 0;                                       // Read by the testbench at the end

    // A stalled beat keeps valid
    hold_valid: assert property (@(posedge aclk) disable iff (!aresetn)
        m_tvalid_i && !m_tready_i |=> m_tvalid_i)
        else
        begin
            $error("m_axis tvalid dropped before the beat was taken");
            fail_cnt++;
        end

    hold_payload: assert property (@(posedge aclk) disable iff (!aresetn)
        m_tvalid_i && !m_tready_i |=> $stable(m_tdata_i) && $stable(m_tlast_i))
        else
        begin
            $error("m_axis tdata or tlast changed while the beat was stalled");
            fail_cnt++;
        end

    // Handshake lines always known
    known_ctrl: assert property (@(posedge aclk) disable iff (!aresetn)
        !$isunknown({m_tvalid_i, s_i_tready_i, s_w_tready_i}))
        else
        begin
            $error("Unknown value on a handshake output");
            fail_cnt++;
        end

    known_data: assert property (@(posedge aclk) disable iff (!aresetn)
        m_tvalid_i |-> !$isunknown({m_tdata_i, m_tlast_i}))
        else
        begin
            $error("Unknown value on m_axis tdata or tlast while valid");
            fail_cnt++;
        end

endmodule
